// File: Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tb_rv_core
FILELIST ?= rv_core.f

BUILD_DIR := obj_dir
BIN       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@! grep -q "Testbench failed" $(LOG)
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: core_pkg.sv
// --------------------
// core level types and constants
// shared by the fetch, load-store, arbiter and execute blocks
// --------------------
package core_pkg;

  // byte address and data word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // register file depth
  localparam int unsigned NUM_REGS = 32;

  // pc step between sequential instructions
  localparam int unsigned INSTR_BYTES = 4;

  // owner of the access in flight on the memory port
  typedef enum logic {
    OWNER_FETCH,
    OWNER_LSU
  } mem_owner_e;

  // execute FSM
  typedef enum logic {
    EX_RUN,
    EX_MEM_WAIT
  } exec_state_e;

endpackage

// File: exec_unit.sv
`timescale 1ns/1ps
// --------------------
// execute stage: decode, register file, ALU and branch resolution
// consumes one buffered instruction at a time, waits on loads and stores,
// and registers one retirement per finished instruction
// --------------------
module exec_unit (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                instr_valid_i,
  input  riscv_pkg::instr_t   instr_i,
  input  core_pkg::addr_t     instr_pc_i,
  output logic                instr_ack_o,
  output logic                redirect_o,
  output core_pkg::addr_t     redirect_pc_o,
  output logic                lsu_req_o,
  output logic                lsu_we_o,
  output core_pkg::addr_t     lsu_addr_o,
  output core_pkg::data_t     lsu_wdata_o,
  input  logic                lsu_done_i,
  input  core_pkg::data_t     lsu_rdata_i,
  output logic                commit_valid_o,
  output core_pkg::addr_t     commit_pc_o,
  output riscv_pkg::reg_idx_t commit_rd_o,
  output core_pkg::data_t     commit_wdata_o
);

  core_pkg::exec_state_e state_q, state_d;
  core_pkg::data_t       rf_q [core_pkg::NUM_REGS];

  // instruction fields
  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  riscv_pkg::reg_idx_t rd, rs1, rs2;
  core_pkg::data_t     rs1_val, rs2_val;
  core_pkg::data_t     imm_i, imm_s, imm_b, imm_j;

  // decode results
  logic                is_mem, is_store, take_jump;
  riscv_pkg::reg_idx_t alu_rd;
  core_pkg::data_t     alu_res;
  core_pkg::addr_t     target;

  // access waiting in the LSU
  core_pkg::addr_t     pend_pc_q;
  riscv_pkg::reg_idx_t pend_rd_q;

  // writeback select
  logic                wb_valid;
  core_pkg::addr_t     wb_pc;
  riscv_pkg::reg_idx_t wb_rd;
  core_pkg::data_t     wb_data;

  assign opcode = instr_i[6:0];
  assign rd     = instr_i[11:7];
  assign funct3 = instr_i[14:12];
  assign rs1    = instr_i[19:15];
  assign rs2    = instr_i[24:20];
  assign funct7 = instr_i[31:25];

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  // x0 reads as zero
  assign rs1_val = (rs1 == '0) ? '0 : rf_q[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : rf_q[rs2];

  // --------------------
  // decode and ALU
  // --------------------
  always_comb begin
    is_mem    = 1'b0;
    is_store  = 1'b0;
    take_jump = 1'b0;
    alu_rd    = '0;
    alu_res   = '0;
    target    = instr_pc_i + imm_b;
    case (opcode)
      riscv_pkg::OPC_OP_IMM: begin
        if (funct3 == riscv_pkg::F3_ADD) begin
          alu_rd  = rd;
          alu_res = rs1_val + imm_i;
        end
      end
      riscv_pkg::OPC_OP: begin
        if (funct3 == riscv_pkg::F3_ADD && funct7 == riscv_pkg::F7_SUB) begin
          alu_rd  = rd;
          alu_res = rs1_val - rs2_val;
        end else if (funct3 == riscv_pkg::F3_ADD && funct7 == '0) begin
          alu_rd  = rd;
          alu_res = rs1_val + rs2_val;
        end
      end
      riscv_pkg::OPC_LOAD: begin
        is_mem = (funct3 == riscv_pkg::F3_LW);
      end
      riscv_pkg::OPC_STORE: begin
        is_mem   = (funct3 == riscv_pkg::F3_SW);
        is_store = (funct3 == riscv_pkg::F3_SW);
      end
      riscv_pkg::OPC_BRANCH: begin
        take_jump = (funct3 == riscv_pkg::F3_BEQ) && (rs1_val == rs2_val);
      end
      riscv_pkg::OPC_JAL: begin
        alu_rd    = rd;
        alu_res   = instr_pc_i + core_pkg::INSTR_BYTES;
        take_jump = 1'b1;
        target    = instr_pc_i + imm_j;
      end
      // anything else retires as a no-op
      default: ;
    endcase
  end

  assign instr_ack_o   = instr_valid_i && (state_q == core_pkg::EX_RUN);
  assign redirect_o    = instr_ack_o && take_jump;
  assign redirect_pc_o = target;
  assign lsu_req_o     = instr_ack_o && is_mem;
  assign lsu_we_o      = is_store;
  assign lsu_addr_o    = rs1_val + (is_store ? imm_s : imm_i);
  assign lsu_wdata_o   = rs2_val;

  // --------------------
  // FSM and writeback
  // --------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      core_pkg::EX_RUN: begin
        if (lsu_req_o) begin
          state_d = core_pkg::EX_MEM_WAIT;
        end
      end
      core_pkg::EX_MEM_WAIT: begin
        if (lsu_done_i) begin
          state_d = core_pkg::EX_RUN;
        end
      end
      default: state_d = core_pkg::EX_RUN;
    endcase
  end

  always_comb begin
    if (state_q == core_pkg::EX_MEM_WAIT) begin
      wb_valid = lsu_done_i;
      wb_pc    = pend_pc_q;
      wb_rd    = pend_rd_q;
      wb_data  = lsu_rdata_i;
    end else begin
      wb_valid = instr_ack_o && !is_mem;
      wb_pc    = instr_pc_i;
      wb_rd    = alu_rd;
      wb_data  = alu_res;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= core_pkg::EX_RUN;
      commit_valid_o <= 1'b0;
    end else begin
      state_q        <= state_d;
      commit_valid_o <= wb_valid;
    end
  end

  // stores keep rd at zero so they retire without a write
  always_ff @(posedge clk_i) begin
    if (lsu_req_o) begin
      pend_pc_q <= instr_pc_i;
      pend_rd_q <= is_store ? '0 : rd;
    end
    if (wb_valid) begin
      commit_pc_o    <= wb_pc;
      commit_rd_o    <= wb_rd;
      commit_wdata_o <= (wb_rd == '0) ? '0 : wb_data;
      if (wb_rd != '0) begin
        rf_q[wb_rd] <= wb_data;
      end
    end
  end

endmodule

// File: fetch_unit.sv
`timescale 1ns/1ps
// --------------------
// instruction fetch with a one-entry buffer
// prefetches the next word while execute works and restarts on a redirect
// --------------------
module fetch_unit (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  core_pkg::addr_t   boot_addr_i,
  output logic              fetch_req_o,
  output core_pkg::addr_t   fetch_addr_o,
  input  logic              fetch_gnt_i,
  input  logic              fetch_rvalid_i,
  input  core_pkg::data_t   fetch_rdata_i,
  output logic              instr_valid_o,
  output riscv_pkg::instr_t instr_o,
  output core_pkg::addr_t   instr_pc_o,
  input  logic              instr_ack_i,
  input  logic              redirect_i,
  input  core_pkg::addr_t   redirect_pc_i
);

  core_pkg::addr_t   pc_q;
  logic              inflight_q;
  logic              discard_q;
  logic              buf_valid_q;
  riscv_pkg::instr_t buf_instr_q;
  core_pkg::addr_t   buf_pc_q;
  logic              fill;

  // a response is kept unless it belongs to the old path
  assign fill = fetch_rvalid_i && !discard_q && !redirect_i;

  assign fetch_req_o   = !inflight_q && (!buf_valid_q || instr_ack_i) && !redirect_i;
  assign fetch_addr_o  = pc_q;
  assign instr_valid_o = buf_valid_q;
  assign instr_o       = buf_valid_q ? buf_instr_q : riscv_pkg::NOP_INSTR;
  assign instr_pc_o    = buf_pc_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q        <= boot_addr_i;
      inflight_q  <= 1'b0;
      discard_q   <= 1'b0;
      buf_valid_q <= 1'b0;
    end else begin
      if (fetch_gnt_i) begin
        inflight_q <= 1'b1;
        pc_q       <= pc_q + core_pkg::INSTR_BYTES;
      end else if (fetch_rvalid_i) begin
        inflight_q <= 1'b0;
      end
      if (redirect_i) begin
        // drop the buffer, mark a response still on its way as stale
        pc_q        <= redirect_pc_i;
        buf_valid_q <= 1'b0;
        discard_q   <= inflight_q && !fetch_rvalid_i;
      end else begin
        if (fetch_rvalid_i) begin
          discard_q <= 1'b0;
        end
        if (fill) begin
          buf_valid_q <= 1'b1;
        end else if (instr_ack_i) begin
          buf_valid_q <= 1'b0;
        end
      end
    end
  end

  // pc_q moved one step past the word on grant and is unchanged since
  always_ff @(posedge clk_i) begin
    if (fill) begin
      buf_instr_q <= fetch_rdata_i;
      buf_pc_q    <= pc_q - core_pkg::INSTR_BYTES;
    end
  end

endmodule

// File: lsu.sv
`timescale 1ns/1ps
// --------------------
// load-store unit
// takes one access from execute, holds it until the arbiter grants it and
// reports completion with the load word
// --------------------
module lsu (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            lsu_req_i,
  input  logic            lsu_we_i,
  input  core_pkg::addr_t lsu_addr_i,
  input  core_pkg::data_t lsu_wdata_i,
  output logic            lsu_done_o,
  output core_pkg::data_t lsu_rdata_o,
  output logic            lsu_mem_req_o,
  output logic            lsu_mem_we_o,
  output core_pkg::addr_t lsu_mem_addr_o,
  output core_pkg::data_t lsu_mem_wdata_o,
  input  logic            lsu_gnt_i,
  input  logic            lsu_rvalid_i,
  input  core_pkg::data_t lsu_mem_rdata_i
);

  logic            req_q;
  logic            wait_q;
  logic            we_q;
  core_pkg::addr_t addr_q;
  core_pkg::data_t wdata_q;

  // request pending until granted, then waiting for the response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q  <= 1'b0;
      wait_q <= 1'b0;
    end else begin
      if (lsu_req_i) begin
        req_q <= 1'b1;
      end else if (lsu_gnt_i) begin
        req_q <= 1'b0;
      end
      if (lsu_gnt_i) begin
        wait_q <= 1'b1;
      end else if (lsu_rvalid_i) begin
        wait_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (lsu_req_i) begin
      we_q    <= lsu_we_i;
      addr_q  <= lsu_addr_i;
      wdata_q <= lsu_wdata_i;
    end
  end

  assign lsu_mem_req_o   = req_q;
  assign lsu_mem_we_o    = we_q;
  assign lsu_mem_addr_o  = addr_q;
  assign lsu_mem_wdata_o = wdata_q;

  // stores complete on the same response, their data is ignored
  assign lsu_done_o  = lsu_rvalid_i && wait_q;
  assign lsu_rdata_o = lsu_mem_rdata_i;

endmodule

// File: mem_arbiter.sv
`timescale 1ns/1ps
// --------------------
// shares the single memory port between fetch and load-store
// load-store has priority, one access in flight, response routed to its owner
// --------------------
module mem_arbiter (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            fetch_req_i,
  input  core_pkg::addr_t fetch_addr_i,
  output logic            fetch_gnt_o,
  output logic            fetch_rvalid_o,
  input  logic            lsu_mem_req_i,
  input  logic            lsu_mem_we_i,
  input  core_pkg::addr_t lsu_mem_addr_i,
  input  core_pkg::data_t lsu_mem_wdata_i,
  output logic            lsu_gnt_o,
  output logic            lsu_rvalid_o,
  output core_pkg::data_t rdata_o,
  output logic            mem_req_o,
  output logic            mem_we_o,
  output core_pkg::addr_t mem_addr_o,
  output core_pkg::data_t mem_wdata_o,
  input  logic            mem_rvalid_i,
  input  core_pkg::data_t mem_rdata_i
);

  logic                 busy_q;
  core_pkg::mem_owner_e owner_q;

  // --------------------
  // grant
  // --------------------
  assign lsu_gnt_o   = lsu_mem_req_i && !busy_q;
  assign fetch_gnt_o = fetch_req_i && !busy_q && !lsu_mem_req_i;

  assign mem_req_o   = lsu_gnt_o || fetch_gnt_o;
  assign mem_we_o    = lsu_gnt_o && lsu_mem_we_i;
  assign mem_addr_o  = lsu_gnt_o ? lsu_mem_addr_i : fetch_addr_i;
  assign mem_wdata_o = lsu_mem_wdata_i;

  // --------------------
  // response routing
  // --------------------
  assign fetch_rvalid_o = mem_rvalid_i && busy_q && (owner_q == core_pkg::OWNER_FETCH);
  assign lsu_rvalid_o   = mem_rvalid_i && busy_q && (owner_q == core_pkg::OWNER_LSU);
  assign rdata_o        = mem_rdata_i;

  // busy from the request until its response comes back
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      owner_q <= core_pkg::OWNER_FETCH;
    end else if (mem_req_o) begin
      busy_q  <= 1'b1;
      owner_q <= lsu_gnt_o ? core_pkg::OWNER_LSU : core_pkg::OWNER_FETCH;
    end else if (mem_rvalid_i) begin
      busy_q <= 1'b0;
    end
  end

endmodule

// File: riscv_pkg.sv
// --------------------
// RV32I instruction set definitions for the core
// opcodes and funct fields of the supported subset, referenced by scoped names
// --------------------
package riscv_pkg;

  // instruction word and register index
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_idx_t;

  // --------------------
  // major opcodes
  // --------------------
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // funct3 values
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_LW  = 3'b010;
  localparam logic [2:0] F3_SW  = 3'b010;
  localparam logic [2:0] F3_BEQ = 3'b000;

  // funct7 selecting SUB over ADD
  localparam logic [6:0] F7_SUB = 7'b0100000;

  // addi x0, x0, 0
  localparam instr_t NOP_INSTR = 32'h0000_0013;

endpackage

// File: rv_core.f
riscv_pkg.sv
core_pkg.sv
fetch_unit.sv
lsu.sv
mem_arbiter.sv
exec_unit.sv
rv_core.sv
rv_core_sva.sv
tb_clock_gen.sv
tb_rv_core.sv

// File: rv_core.sv
`timescale 1ns/1ps
// --------------------
// top level of the RV32I core
// fetch and load-store share one memory port, retirements leave on commit_*
// --------------------
module rv_core (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  core_pkg::addr_t     boot_addr_i,
  output logic                mem_req_o,
  output logic                mem_we_o,
  output core_pkg::addr_t     mem_addr_o,
  output core_pkg::data_t     mem_wdata_o,
  input  logic                mem_rvalid_i,
  input  core_pkg::data_t     mem_rdata_i,
  output logic                commit_valid_o,
  output core_pkg::addr_t     commit_pc_o,
  output riscv_pkg::reg_idx_t commit_rd_o,
  output core_pkg::data_t     commit_wdata_o
);

  // fetch and LSU to arbiter
  logic              fetch_req, fetch_gnt, fetch_rvalid;
  core_pkg::addr_t   fetch_addr;
  logic              lsu_mem_req, lsu_mem_we, lsu_gnt, lsu_rvalid;
  core_pkg::addr_t   lsu_mem_addr;
  core_pkg::data_t   lsu_mem_wdata;
  core_pkg::data_t   arb_rdata;

  // fetch to execute
  logic              instr_valid, instr_ack, redirect;
  riscv_pkg::instr_t instr;
  core_pkg::addr_t   instr_pc, redirect_pc;

  // execute to LSU
  logic              lsu_req, lsu_we, lsu_done;
  core_pkg::addr_t   lsu_addr;
  core_pkg::data_t   lsu_wdata, lsu_rdata;

  fetch_unit i_fetch_unit (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .boot_addr_i    ( boot_addr_i  ),
    .fetch_req_o    ( fetch_req    ),
    .fetch_addr_o   ( fetch_addr   ),
    .fetch_gnt_i    ( fetch_gnt    ),
    .fetch_rvalid_i ( fetch_rvalid ),
    .fetch_rdata_i  ( arb_rdata    ),
    .instr_valid_o  ( instr_valid  ),
    .instr_o        ( instr        ),
    .instr_pc_o     ( instr_pc     ),
    .instr_ack_i    ( instr_ack    ),
    .redirect_i     ( redirect     ),
    .redirect_pc_i  ( redirect_pc  )
  );

  lsu i_lsu (
    .clk_i           ( clk_i         ),
    .rst_ni          ( rst_ni        ),
    .lsu_req_i       ( lsu_req       ),
    .lsu_we_i        ( lsu_we        ),
    .lsu_addr_i      ( lsu_addr      ),
    .lsu_wdata_i     ( lsu_wdata     ),
    .lsu_done_o      ( lsu_done      ),
    .lsu_rdata_o     ( lsu_rdata     ),
    .lsu_mem_req_o   ( lsu_mem_req   ),
    .lsu_mem_we_o    ( lsu_mem_we    ),
    .lsu_mem_addr_o  ( lsu_mem_addr  ),
    .lsu_mem_wdata_o ( lsu_mem_wdata ),
    .lsu_gnt_i       ( lsu_gnt       ),
    .lsu_rvalid_i    ( lsu_rvalid    ),
    .lsu_mem_rdata_i ( arb_rdata     )
  );

  mem_arbiter i_mem_arbiter (
    .clk_i           ( clk_i         ),
    .rst_ni          ( rst_ni        ),
    .fetch_req_i     ( fetch_req     ),
    .fetch_addr_i    ( fetch_addr    ),
    .fetch_gnt_o     ( fetch_gnt     ),
    .fetch_rvalid_o  ( fetch_rvalid  ),
    .lsu_mem_req_i   ( lsu_mem_req   ),
    .lsu_mem_we_i    ( lsu_mem_we    ),
    .lsu_mem_addr_i  ( lsu_mem_addr  ),
    .lsu_mem_wdata_i ( lsu_mem_wdata ),
    .lsu_gnt_o       ( lsu_gnt       ),
    .lsu_rvalid_o    ( lsu_rvalid    ),
    .rdata_o         ( arb_rdata     ),
    .mem_req_o       ( mem_req_o     ),
    .mem_we_o        ( mem_we_o      ),
    .mem_addr_o      ( mem_addr_o    ),
    .mem_wdata_o     ( mem_wdata_o   ),
    .mem_rvalid_i    ( mem_rvalid_i  ),
    .mem_rdata_i     ( mem_rdata_i   )
  );

  exec_unit i_exec_unit (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .instr_valid_i  ( instr_valid    ),
    .instr_i        ( instr          ),
    .instr_pc_i     ( instr_pc       ),
    .instr_ack_o    ( instr_ack      ),
    .redirect_o     ( redirect       ),
    .redirect_pc_o  ( redirect_pc    ),
    .lsu_req_o      ( lsu_req        ),
    .lsu_we_o       ( lsu_we         ),
    .lsu_addr_o     ( lsu_addr       ),
    .lsu_wdata_o    ( lsu_wdata      ),
    .lsu_done_i     ( lsu_done       ),
    .lsu_rdata_i    ( lsu_rdata      ),
    .commit_valid_o ( commit_valid_o ),
    .commit_pc_o    ( commit_pc_o    ),
    .commit_rd_o    ( commit_rd_o    ),
    .commit_wdata_o ( commit_wdata_o )
  );

endmodule

// File: rv_core_sva.sv
`timescale 1ns/1ps
// --------------------
// memory port and retire port properties, bound into every rv_core
// --------------------
module rv_core_sva (
  input logic clk_i,
  input logic rst_ni,
  input logic mem_req_o,
  input logic mem_rvalid_i,
  input logic commit_valid_o
);

  // request issued, response not back yet
  logic pending_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else if (mem_req_o) begin
      pending_q <= 1'b1;
    end else if (mem_rvalid_i) begin
      pending_q <= 1'b0;
    end
  end

  a_no_req_while_pending : assert property (
    @(posedge clk_i) disable iff (!rst_ni) pending_q |-> !mem_req_o
  ) else $error("memory request issued while a response is pending");

  a_no_commit_in_reset : assert property (
    @(posedge clk_i) (!rst_ni && $past(!rst_ni)) |-> !commit_valid_o
  ) else $error("retire reported during reset");

  a_rvalid_follows_req : assert property (
    @(posedge clk_i) disable iff (!rst_ni) mem_req_o |=> mem_rvalid_i
  ) else $error("no memory response one cycle after a request");

endmodule

bind rv_core rv_core_sva i_rv_core_sva (
  .clk_i          ( clk_i          ),
  .rst_ni         ( rst_ni         ),
  .mem_req_o      ( mem_req_o      ),
  .mem_rvalid_i   ( mem_rvalid_i   ),
  .commit_valid_o ( commit_valid_o )
);

// File: tb_clock_gen.sv
`timescale 1ns/1ps
// --------------------
// testbench clock and power-on reset
// 100 ns clock, reset held low for the first 16 rising edges
// --------------------
module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (16) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// File: tb_rv_core.sv
`timescale 1ns/1ps
// --------------------
// directed testbench for the RV32I core
// memory model answers one cycle after each request, retirements are
// collected in order and compared against an ISA-level prediction
// --------------------
module tb_rv_core;

  localparam int unsigned NUM_TESTS       = 5;
  localparam int unsigned TEST_BUDGET     = 200;
  localparam int unsigned WATCHDOG_CYCLES = NUM_TESTS * (TEST_BUDGET + 24) + 100;

  logic        clk_i;
  logic        gen_rst_n;
  logic        test_rst_n = 1'b1;
  logic        rst_ni;
  logic [31:0] boot_addr_i = 32'h0;
  logic        mem_req_o, mem_we_o, commit_valid_o;
  logic [31:0] mem_addr_o, mem_wdata_o, commit_pc_o, commit_wdata_o;
  logic [4:0]  commit_rd_o;
  logic        mem_rvalid_i = 1'b0;
  logic [31:0] mem_rdata_i = 32'h0;

  // memory, writes seen on the port and retire stream
  logic [31:0] mem [logic [29:0]];
  logic [31:0] wr_addr_q[$], wr_data_q[$];
  logic [31:0] ret_pc_q[$], ret_rd_q[$], ret_wd_q[$];
  logic [31:0] exp_pc_q[$], exp_rd_q[$], exp_wd_q[$];
  logic [31:0] first_req_addr;
  logic        req_seen;
  logic [31:0] lfsr_q = 32'h5f97_4fa6;
  logic [31:0] load_pc;
  int unsigned errors, tests_ok, tests_bad;

  assign rst_ni = gen_rst_n && test_rst_n;

  tb_clock_gen i_tb_clock_gen (
    .clk_o  ( clk_i     ),
    .rst_no ( gen_rst_n )
  );

  rv_core i_rv_core (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .boot_addr_i    ( boot_addr_i    ),
    .mem_req_o      ( mem_req_o      ),
    .mem_we_o       ( mem_we_o       ),
    .mem_addr_o     ( mem_addr_o     ),
    .mem_wdata_o    ( mem_wdata_o    ),
    .mem_rvalid_i   ( mem_rvalid_i   ),
    .mem_rdata_i    ( mem_rdata_i    ),
    .commit_valid_o ( commit_valid_o ),
    .commit_pc_o    ( commit_pc_o    ),
    .commit_rd_o    ( commit_rd_o    ),
    .commit_wdata_o ( commit_wdata_o )
  );

  // --------------------
  // helpers
  // --------------------
  // galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // unwritten words decode as an unknown opcode, i.e. a no-op
  function automatic logic [31:0] read_word(logic [31:0] addr);
    if (mem.exists(addr[31:2])) begin
      return mem[addr[31:2]];
    end
    return {addr[24:0] ^ addr[31:7], 7'b0000000};
  endfunction

  function automatic logic [31:0] sext12(logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] enc_addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, riscv_pkg::F3_ADD, rd, riscv_pkg::OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] enc_op(logic [6:0] f7, logic [4:0] rd, logic [4:0] rs1,
                                         logic [4:0] rs2);
    return {f7, rs2, rs1, riscv_pkg::F3_ADD, rd, riscv_pkg::OPC_OP};
  endfunction

  function automatic logic [31:0] enc_lw(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    return {imm, rs1, riscv_pkg::F3_LW, rd, riscv_pkg::OPC_LOAD};
  endfunction

  function automatic logic [31:0] enc_sw(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
    return {imm[11:5], rs2, rs1, riscv_pkg::F3_SW, imm[4:0], riscv_pkg::OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_beq(logic [4:0] rs1, logic [4:0] rs2, logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, riscv_pkg::F3_BEQ, off[4:1], off[11],
            riscv_pkg::OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_jal(logic [4:0] rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, riscv_pkg::OPC_JAL};
  endfunction

  task automatic check(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %08h expected %08h", $time, name, got, exp);
      errors++;
    end
  endtask

  // --------------------
  // memory model
  // --------------------
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      mem_rvalid_i <= 1'b0;
    end else begin
      mem_rvalid_i <= mem_req_o;
      if (mem_req_o) begin
        if (!req_seen) begin
          first_req_addr = mem_addr_o;
          req_seen = 1'b1;
        end
        if (mem_we_o) begin
          mem[mem_addr_o[31:2]] = mem_wdata_o;
          wr_addr_q.push_back(mem_addr_o);
          wr_data_q.push_back(mem_wdata_o);
        end else begin
          mem_rdata_i <= read_word(mem_addr_o);
        end
      end
      if (commit_valid_o) begin
        ret_pc_q.push_back(commit_pc_o);
        ret_rd_q.push_back({27'b0, commit_rd_o});
        ret_wd_q.push_back(commit_wdata_o);
      end
    end
  end

  // --------------------
  // test sequencing
  // --------------------
  task automatic begin_test(logic [31:0] boot);
    @(posedge clk_i);
    test_rst_n  <= 1'b0;
    boot_addr_i <= boot;
    @(posedge clk_i);
    mem.delete();
    wr_addr_q.delete();
    wr_data_q.delete();
    ret_pc_q.delete();
    ret_rd_q.delete();
    ret_wd_q.delete();
    exp_pc_q.delete();
    exp_rd_q.delete();
    exp_wd_q.delete();
    req_seen = 1'b0;
    load_pc  = boot;
  endtask

  // place one instruction, optionally with its expected retirement
  task automatic put(logic [31:0] instr);
    mem[load_pc[31:2]] = instr;
    load_pc += 32'd4;
  endtask

  task automatic emit(logic [31:0] instr, logic [31:0] rd, logic [31:0] wd);
    exp_pc_q.push_back(load_pc);
    exp_rd_q.push_back(rd);
    exp_wd_q.push_back(wd);
    put(instr);
  endtask

  task automatic run_and_check();
    int unsigned n;
    repeat (16) @(posedge clk_i);
    test_rst_n <= 1'b1;
    n = 0;
    while (ret_pc_q.size() < exp_pc_q.size() && n < TEST_BUDGET) begin
      @(posedge clk_i);
      n++;
    end
    if (ret_pc_q.size() < exp_pc_q.size()) begin
      $display("timeout: only %0d of %0d instructions retired", ret_pc_q.size(),
               exp_pc_q.size());
      errors++;
    end else begin
      foreach (exp_pc_q[i]) begin
        check("commit_pc_o", ret_pc_q[i], exp_pc_q[i]);
        check("commit_rd_o", ret_rd_q[i], exp_rd_q[i]);
        check("commit_wdata_o", ret_wd_q[i], exp_wd_q[i]);
      end
    end
  endtask

  task automatic end_test(string name, int unsigned err0);
    if (errors == err0) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: FAILED with %0d errors", name, errors - err0);
    end
  endtask

  function automatic logic [31:0] rand_boot();
    logic [31:0] t;
    t = rand_bits(12);
    return 32'h0000_4000 | {18'b0, t[11:0], 2'b00};
  endfunction

  // --------------------
  // directed tests
  // --------------------
  task automatic test_boot();
    int unsigned err0;
    logic [31:0] boot, imm;
    err0 = errors;
    boot = rand_boot();
    imm  = rand_bits(12);
    begin_test(boot);
    emit(enc_addi(5'd1, 5'd0, imm[11:0]), 32'd1, sext12(imm[11:0]));
    put(enc_jal(5'd0, 21'd0));
    run_and_check();
    if (!req_seen) begin
      $display("no memory request was seen after reset");
      errors++;
    end else begin
      check("mem_addr_o", first_req_addr, boot);
    end
    end_test("boot", err0);
  endtask

  task automatic test_alu_chain();
    int unsigned err0;
    logic [31:0] r [8];
    logic [31:0] t, imm;
    logic [4:0]  rd, rs1, rs2;
    err0 = errors;
    r[0] = '0;
    begin_test(rand_boot());
    for (int unsigned k = 1; k < 8; k++) begin
      imm  = rand_bits(12);
      r[k] = sext12(imm[11:0]);
      emit(enc_addi(5'(k), 5'd0, imm[11:0]), k, r[k]);
    end
    for (int unsigned k = 0; k < 8; k++) begin
      t   = rand_bits(3);
      rd  = (t[2:0] == 3'd0) ? 5'd7 : {2'b00, t[2:0]};
      t   = rand_bits(3);
      rs1 = {2'b00, t[2:0]};
      t   = rand_bits(3);
      rs2 = {2'b00, t[2:0]};
      t   = rand_bits(2);
      imm = rand_bits(12);
      if (t[1:0] == 2'd0) begin
        r[rd[2:0]] = r[rs1[2:0]] + sext12(imm[11:0]);
        emit(enc_addi(rd, rs1, imm[11:0]), {27'b0, rd}, r[rd[2:0]]);
      end else if (t[1:0] == 2'd1) begin
        r[rd[2:0]] = r[rs1[2:0]] + r[rs2[2:0]];
        emit(enc_op(7'b0000000, rd, rs1, rs2), {27'b0, rd}, r[rd[2:0]]);
      end else begin
        r[rd[2:0]] = r[rs1[2:0]] - r[rs2[2:0]];
        emit(enc_op(riscv_pkg::F7_SUB, rd, rs1, rs2), {27'b0, rd}, r[rd[2:0]]);
      end
    end
    put(enc_jal(5'd0, 21'd0));
    run_and_check();
    end_test("alu_chain", err0);
  endtask

  task automatic test_store_load();
    int unsigned err0;
    logic [31:0] t, base, data;
    err0 = errors;
    t    = rand_bits(7);
    base = {20'b0, 3'b001, t[6:0], 2'b00};
    t    = rand_bits(12);
    data = sext12(t[11:0]);
    begin_test(rand_boot());
    emit(enc_addi(5'd1, 5'd0, base[11:0]), 32'd1, base);
    emit(enc_addi(5'd2, 5'd0, t[11:0]), 32'd2, data);
    emit(enc_sw(5'd2, 5'd1, 12'd8), 32'd0, 32'd0);
    emit(enc_lw(5'd3, 5'd1, 12'd8), 32'd3, data);
    put(enc_jal(5'd0, 21'd0));
    run_and_check();
    if (wr_addr_q.size() != 1) begin
      $display("expected one memory write, saw %0d", wr_addr_q.size());
      errors++;
    end else begin
      check("mem_addr_o", wr_addr_q[0], base + 32'd8);
      check("mem_wdata_o", wr_data_q[0], data);
    end
    end_test("store_load", err0);
  endtask

  task automatic test_branch_jump();
    int unsigned err0;
    logic [31:0] boot;
    err0 = errors;
    boot = rand_boot();
    begin_test(boot);
    emit(enc_addi(5'd1, 5'd0, 12'd5), 32'd1, 32'd5);
    emit(enc_addi(5'd2, 5'd0, 12'd5), 32'd2, 32'd5);
    // taken, skips one instruction
    emit(enc_beq(5'd1, 5'd2, 13'd8), 32'd0, 32'd0);
    put(enc_addi(5'd3, 5'd0, 12'd1));
    emit(enc_addi(5'd4, 5'd0, 12'd2), 32'd4, 32'd2);
    // not taken
    emit(enc_beq(5'd1, 5'd4, 13'd8), 32'd0, 32'd0);
    emit(enc_jal(5'd5, 21'd8), 32'd5, boot + 32'd28);
    put(enc_addi(5'd6, 5'd0, 12'd3));
    emit(enc_jal(5'd0, 21'd0), 32'd0, 32'd0);
    run_and_check();
    end_test("branch_jump", err0);
  endtask

  task automatic test_x0_unknown();
    int unsigned err0;
    err0 = errors;
    begin_test(rand_boot());
    emit(enc_addi(5'd0, 5'd0, 12'd77), 32'd0, 32'd0);
    emit(enc_addi(5'd1, 5'd0, 12'd9), 32'd1, 32'd9);
    emit(enc_op(7'b0000000, 5'd2, 5'd0, 5'd1), 32'd2, 32'd9);
    // opcode 7f with rd field 31
    emit(32'h0000_0fff, 32'd0, 32'd0);
    emit(enc_op(7'b0000000, 5'd3, 5'd0, 5'd0), 32'd3, 32'd0);
    put(enc_jal(5'd0, 21'd0));
    run_and_check();
    end_test("x0_unknown", err0);
  endtask

  // --------------------
  // main and watchdog
  // --------------------
  initial begin
    errors    = 0;
    tests_ok  = 0;
    tests_bad = 0;
    req_seen  = 1'b0;
    wait (gen_rst_n);
    @(posedge clk_i);
    test_boot();
    test_alu_chain();
    test_store_load();
    test_branch_jump();
    test_x0_unknown();
    $display("%0d tests: %0d ok, %0d failed, %0d errors", NUM_TESTS, tests_ok, tests_bad,
             errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("watchdog expired before all tests finished");
    $display("Testbench failed");
    $finish;
  end

endmodule
